//--- run_sim.sh
#!/bin/sh
# Build and run the chip-control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sim.f --top-module chip_ctrl_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vchip_ctrl_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- sim.f
+incdir+src
src/chip_ctrl_pkg.sv
src/chip_ctrl_decode.sv
src/clk_ctrl_regs.sv
src/pad_cfg_regs.sv
src/chip_ctrl_top.sv
tb/chip_ctrl_tb.sv

//--- src/chip_ctrl_config.svh
//////////////////////////////////////////////////////////////////////
// Address map and sizing of the chip-control block
// Region bases and sizes are 12-bit literals and must follow the
// address width if that is ever changed
// Each region is a power of two in size and aligned to its size
//////////////////////////////////////////////////////////////////////

`ifndef CHIP_CTRL_CONFIG_SVH
`define CHIP_CTRL_CONFIG_SVH

// APB bus widths
`define CHIP_CTRL_ADDR_W 12
`define CHIP_CTRL_DATA_W 32

// Clock control region at 0x000 to 0x0FF
`define CLK_CTRL_BASE 12'h000
`define CLK_CTRL_SIZE 12'h100

// Pad configuration region at 0x100 to 0x1FF
`define PAD_CFG_BASE 12'h100
`define PAD_CFG_SIZE 12'h100

// Register offsets inside the clock region
`define CLK_EN_OFFS  12'h000
`define CLK_BYP_OFFS 12'h004

// General purpose pads and their function select width
`define PAD_COUNT 8
`define PAD_SEL_W 2

// Every clock is running after reset
`define CLK_EN_RESET 3'b111

`endif

//--- src/chip_ctrl_decode.sv
//////////////////////////////////////////////////////////////////////
// APB region decoder of the chip-control block
// Only the region is decoded here, targets decode their own offsets
// Unmapped addresses get a zero-wait error response
// Clock input only samples the assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "chip_ctrl_config.svh"

module chip_ctrl_decode import chip_ctrl_pkg::*; (
  input  logic     clk_soc_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output apb_req_t clk_req_o,
  input  apb_rsp_t clk_rsp_i,
  output apb_req_t pad_req_o,
  input  apb_rsp_t pad_rsp_i
);

  // Masks keep only the region bits of paddr
  localparam apb_addr_t clk_mask = ~apb_addr_t'(`CLK_CTRL_SIZE - 1);
  localparam apb_addr_t pad_mask = ~apb_addr_t'(`PAD_CFG_SIZE - 1);

  logic     clk_hit;
  logic     pad_hit;
  logic     err_hit;
  apb_rsp_t err_rsp;

  //////////////////////////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////////////////////////

  assign clk_hit = (apb_req_i.paddr & clk_mask) == apb_addr_t'(`CLK_CTRL_BASE);
  assign pad_hit = (apb_req_i.paddr & pad_mask) == apb_addr_t'(`PAD_CFG_BASE);
  // Anything else falls to the error target
  assign err_hit = !(clk_hit || pad_hit);

  //////////////////////////////////////////////////////////////////////
  // Request routing
  //////////////////////////////////////////////////////////////////////

  // Address, data and direction go to both targets unchanged
  // Only the selected target sees psel and penable
  always_comb begin
    clk_req_o         = apb_req_i;
    clk_req_o.psel    = apb_req_i.psel & clk_hit;
    clk_req_o.penable = apb_req_i.penable & clk_hit;
    pad_req_o         = apb_req_i;
    pad_req_o.psel    = apb_req_i.psel & pad_hit;
    pad_req_o.penable = apb_req_i.penable & pad_hit;
  end

  // Error target
  // completes in the access phase with zero data
  assign err_rsp.prdata  = '0;
  assign err_rsp.pready  = apb_req_i.psel & apb_req_i.penable & err_hit;
  assign err_rsp.pslverr = apb_req_i.psel & apb_req_i.penable & err_hit;

  //////////////////////////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (err_hit) begin
      apb_rsp_o = err_rsp;
    end else if (clk_hit) begin
      apb_rsp_o = clk_rsp_i;
    end else begin
      apb_rsp_o = pad_rsp_i;
    end
  end

  // Never two targets on the bus at once
  a_one_target: assert property (@(posedge clk_soc_i)
    $onehot0({clk_req_o.psel, pad_req_o.psel}))
    else $error("more than one register target selected");

  // All targets are zero wait state, whichever one answers
  a_access_done: assert property (@(posedge clk_soc_i)
    apb_req_i.psel && apb_req_i.penable |-> apb_rsp_o.pready)
    else $error("access phase without pready");

endmodule

//--- src/chip_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the chip-control block
// Clock domain bit index used by both clock registers
//   bit 0 is soc, bit 1 is per, bit 2 is slow
//////////////////////////////////////////////////////////////////////

`include "chip_ctrl_config.svh"

package chip_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////////////////////////

  // APB address and data words
  typedef logic [`CHIP_CTRL_ADDR_W-1:0] apb_addr_t;
  typedef logic [`CHIP_CTRL_DATA_W-1:0] apb_data_t;

  // Function select of one pad
  typedef logic [`PAD_SEL_W-1:0] pad_sel_t;

  // All pad selects, pad 0 in the low bits
  typedef pad_sel_t [`PAD_COUNT-1:0] pad_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // APB request and response
  //////////////////////////////////////////////////////////////////////

  // Master to slave, 47 bits
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Clock enables and effective bypasses, soc_en is the MSB
  typedef struct packed {
    logic soc_en;
    logic soc_byp;
    logic per_en;
    logic per_byp;
    logic slow_en;
    logic slow_byp;
  } clk_ctrl_t;

endpackage

//--- src/chip_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// Chip-control top level
// APB slave on the soc clock with a synchronous active-low reset
// Clock region at 0x000, pad region at 0x100, other addresses error
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module chip_ctrl_top import chip_ctrl_pkg::*; (
  input  logic      clk_soc_i,
  input  logic      rst_n_i,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  logic      pad_clk_byp_i,
  input  logic      jtag_clk_byp_i,
  output clk_ctrl_t clk_ctrl_o,
  output pad_cfg_t  pad_cfg_o
);

  // Routed buses between decoder and targets
  apb_req_t clk_req;
  apb_rsp_t clk_rsp;
  apb_req_t pad_req;
  apb_rsp_t pad_rsp;

  //////////////////////////////////////////////////////////////////////
  // Region decoder
  //////////////////////////////////////////////////////////////////////

  chip_ctrl_decode i_decode (
    .clk_soc_i ( clk_soc_i ),
    .apb_req_i ( apb_req_i ),
    .apb_rsp_o ( apb_rsp_o ),
    .clk_req_o ( clk_req   ),
    .clk_rsp_i ( clk_rsp   ),
    .pad_req_o ( pad_req   ),
    .pad_rsp_i ( pad_rsp   )
  );

  //////////////////////////////////////////////////////////////////////
  // Register targets
  //////////////////////////////////////////////////////////////////////

  // Clock enables, bypass bits and external bypass merge
  clk_ctrl_regs i_clk_ctrl_regs (
    .clk_soc_i      ( clk_soc_i      ),
    .rst_n_i        ( rst_n_i        ),
    .apb_req_i      ( clk_req        ),
    .apb_rsp_o      ( clk_rsp        ),
    .pad_clk_byp_i  ( pad_clk_byp_i  ),
    .jtag_clk_byp_i ( jtag_clk_byp_i ),
    .clk_ctrl_o     ( clk_ctrl_o     )
  );

  // Pad multiplexer selects
  pad_cfg_regs i_pad_cfg_regs (
    .clk_soc_i ( clk_soc_i ),
    .rst_n_i   ( rst_n_i   ),
    .apb_req_i ( pad_req   ),
    .apb_rsp_o ( pad_rsp   ),
    .pad_cfg_o ( pad_cfg_o )
  );

endmodule

//--- src/clk_ctrl_regs.sv
//////////////////////////////////////////////////////////////////////
// Clock enable and bypass registers
// Zero wait states, pslverr is never raised
// Unknown offsets in the region are ignored on write and read zero
// Pad and JTAG bypass pins force every clock into bypass
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "chip_ctrl_config.svh"

module clk_ctrl_regs import chip_ctrl_pkg::*; (
  input  logic      clk_soc_i,
  input  logic      rst_n_i,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  logic      pad_clk_byp_i,
  input  logic      jtag_clk_byp_i,
  output clk_ctrl_t clk_ctrl_o
);

  // Offset inside the clock region
  localparam apb_addr_t offs_mask = apb_addr_t'(`CLK_CTRL_SIZE - 1);

  apb_addr_t offs;
  logic      access;
  logic      wr_en;
  // Bit 0 soc, bit 1 per, bit 2 slow
  logic [2:0] en_q;
  logic [2:0] byp_q;
  logic       ext_byp;

  assign offs   = apb_req_i.paddr & offs_mask;
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  // Write lands on the edge that closes the access phase
  always_ff @(posedge clk_soc_i) begin
    if (!rst_n_i) begin
      en_q  <= `CLK_EN_RESET;
      byp_q <= '0;
    end else if (wr_en) begin
      if (offs == `CLK_EN_OFFS) begin
        en_q <= apb_req_i.pwdata[2:0];
      end
      if (offs == `CLK_BYP_OFFS) begin
        byp_q <= apb_req_i.pwdata[2:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read path and handshake
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    apb_rsp_o.prdata = '0;
    if (access && !apb_req_i.pwrite) begin
      if (offs == `CLK_EN_OFFS) begin
        apb_rsp_o.prdata = apb_data_t'(en_q);
      end else if (offs == `CLK_BYP_OFFS) begin
        apb_rsp_o.prdata = apb_data_t'(byp_q);
      end
    end
  end

  // Ready in every access phase
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Bypass merge
  //////////////////////////////////////////////////////////////////////

  // Either external source bypasses all three clocks
  assign ext_byp = pad_clk_byp_i | jtag_clk_byp_i;

  assign clk_ctrl_o.soc_en   = en_q[0];
  assign clk_ctrl_o.soc_byp  = byp_q[0] | ext_byp;
  assign clk_ctrl_o.per_en   = en_q[1];
  assign clk_ctrl_o.per_byp  = byp_q[1] | ext_byp;
  assign clk_ctrl_o.slow_en  = en_q[2];
  assign clk_ctrl_o.slow_byp = byp_q[2] | ext_byp;

  // Decoder gates penable together with psel
  a_penable_psel: assert property (@(posedge clk_soc_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_req_i.psel)
    else $error("penable without psel on clock registers");

endmodule

//--- src/pad_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// Pad function select register file
// One word per pad, index is the word offset in the region
// Byte offset bits are ignored
// Indices from PAD_COUNT up ignore writes and read zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "chip_ctrl_config.svh"

module pad_cfg_regs import chip_ctrl_pkg::*; (
  input  logic     clk_soc_i,
  input  logic     rst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output pad_cfg_t pad_cfg_o
);

  localparam apb_addr_t offs_mask = apb_addr_t'(`PAD_CFG_SIZE - 1);

  apb_addr_t idx;
  logic      access;
  logic      wr_en;
  pad_cfg_t  cfg_q;

  // Per-pad change mask between two snapshots
  function automatic logic [`PAD_COUNT-1:0] field_diff(pad_cfg_t a, pad_cfg_t b);
    logic [`PAD_COUNT-1:0] diff;
    for (int i = 0; i < `PAD_COUNT; i++) begin
      diff[i] = a[i] != b[i];
    end
    return diff;
  endfunction

  // Word index within the region
  assign idx    = (apb_req_i.paddr & offs_mask) >> 2;
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  //////////////////////////////////////////////////////////////////////
  // Select registers
  //////////////////////////////////////////////////////////////////////

  // Out-of-range indices match no pad and drop out here
  always_ff @(posedge clk_soc_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < `PAD_COUNT; i++) begin
        if (idx == apb_addr_t'(i)) begin
          cfg_q[i] <= apb_req_i.pwdata[`PAD_SEL_W-1:0];
        end
      end
    end
  end

  assign pad_cfg_o = cfg_q;

  //////////////////////////////////////////////////////////////////////
  // Read path and handshake
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    apb_rsp_o.prdata = '0;
    if (access && !apb_req_i.pwrite) begin
      for (int i = 0; i < `PAD_COUNT; i++) begin
        if (idx == apb_addr_t'(i)) begin
          apb_rsp_o.prdata = apb_data_t'(cfg_q[i]);
        end
      end
    end
  end

  // Zero wait, no error even on empty indices
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = 1'b0;

  // A single access touches one pad at most
  a_one_pad: assert property (@(posedge clk_soc_i) disable iff (!rst_n_i)
    $onehot0(field_diff(cfg_q, $past(cfg_q))))
    else $error("more than one pad select changed in one cycle");

endmodule

//--- tb/chip_ctrl_patterns.txt
# op addr wdata pad_byp jtag_byp exp_prdata exp_pslverr exp_clk_ctrl
# values in hex, exp_clk_ctrl is checked the cycle after the access
# reset values
R 000 00000000 0 0 00000007 0 2a
R 004 00000000 0 0 00000000 0 2a
R 100 00000000 0 0 00000000 0 2a
# clock register writes and read back
W 000 fffffff5 0 0 00000000 0 22
R 000 00000000 0 0 00000005 0 22
W 004 0000000a 0 0 00000000 0 26
R 004 00000000 0 0 00000002 0 26
# bypass pins override the bypass register
R 004 00000000 1 0 00000002 0 37
R 000 00000000 0 1 00000005 0 37
R 000 00000000 0 0 00000005 0 26
W 004 00000005 0 0 00000000 0 33
W 000 00000002 0 1 00000000 0 1d
R 000 00000000 0 0 00000002 0 19
# undefined clock offsets
W 008 0000ffff 0 0 00000000 0 19
R 008 00000000 0 0 00000000 0 19
R 0fc 00000000 0 0 00000000 0 19
# error target
W 200 00000007 0 0 00000000 1 19
R 200 00000000 0 0 00000000 1 19
W 30c 00000003 0 0 00000000 1 19
R ffc 00000000 0 0 00000000 1 19
# pad registers, index 8 is empty
W 10c 00000003 0 0 00000000 0 19
R 10c 00000000 0 0 00000003 0 19
W 120 00000002 0 0 00000000 0 19
R 120 00000000 0 0 00000000 0 19
# back to the reset clock setting
W 000 00000007 0 0 00000000 0 3b
W 004 00000000 0 0 00000000 0 2a

//--- tb/chip_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the chip-control block
// Directed accesses come from tb/chip_ctrl_patterns.txt, read from
// the project root, followed by a random pad register sweep
// Stops at the first mismatch, a watchdog bounds the run time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "chip_ctrl_config.svh"

module chip_ctrl_tb import chip_ctrl_pkg::*;;

  localparam int RAND_WRITES = 32;

  // One directed access with its expected results
  typedef struct packed {
    logic      wr;
    apb_addr_t addr;
    apb_data_t wdata;
    logic      pad_byp;
    logic      jtag_byp;
    apb_data_t exp_rdata;
    logic      exp_err;
    logic [5:0] exp_clk;
  } pattern_t;

  logic      clk_soc_i;
  logic      rst_n;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      pad_clk_byp;
  logic      jtag_clk_byp;
  clk_ctrl_t clk_ctrl;
  pad_cfg_t  pad_cfg;

  pattern_t  pats[$];
  // Expected pad selects
  pad_cfg_t  pad_model;
  logic [31:0] seed;
  int        cycles = 0;
  int        limit = 50;

  chip_ctrl_top i_chip_ctrl_top (
    .clk_soc_i      ( clk_soc_i    ),
    .rst_n_i        ( rst_n        ),
    .apb_req_i      ( apb_req      ),
    .apb_rsp_o      ( apb_rsp      ),
    .pad_clk_byp_i  ( pad_clk_byp  ),
    .jtag_clk_byp_i ( jtag_clk_byp ),
    .clk_ctrl_o     ( clk_ctrl     ),
    .pad_cfg_o      ( pad_cfg      )
  );

  // 40 ns soc clock
  initial begin
    clk_soc_i = 1'b0;
    forever #20 clk_soc_i = ~clk_soc_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Numerical Recipes LCG constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Run time bound, armed once the pattern count is known
  always @(posedge clk_soc_i) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      abort_run($sformatf("Timeout, the run did not end within %0d cycles", limit));
    end
  end

  // Reads the directed accesses, lines starting with # are skipped
  task automatic load_patterns();
    int              fd;
    int              code;
    string           tok;
    logic [8*160-1:0] skip_line;
    pattern_t        p;
    apb_addr_t       a;
    apb_data_t       d;
    apb_data_t       er;
    logic            pb;
    logic            jb;
    logic            ee;
    logic [5:0]      ec;
    fd = $fopen("tb/chip_ctrl_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the pattern file tb/chip_ctrl_patterns.txt");
    end
    while (1) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok[0] == "#") begin
        code = $fgets(skip_line, fd);
        continue;
      end
      if (tok != "W" && tok != "R") begin
        abort_run($sformatf("Unknown operation %s in the pattern file", tok));
      end
      code = $fscanf(fd, " %h %h %h %h %h %h %h", a, d, pb, jb, er, ee, ec);
      if (code != 7) begin
        abort_run("A pattern line has too few columns");
      end
      p.wr        = (tok == "W");
      p.addr      = a;
      p.wdata     = d;
      p.pad_byp   = pb;
      p.jtag_byp  = jb;
      p.exp_rdata = er;
      p.exp_err   = ee;
      p.exp_clk   = ec;
      pats.push_back(p);
    end
    $fclose(fd);
  endtask

  // Pad rule: word index in the pad region, indices from PAD_COUNT ignored
  task automatic update_pad_model(input logic wr, input apb_addr_t addr,
                                  input apb_data_t wdata);
    int idx;
    if (wr && addr >= `PAD_CFG_BASE && addr < `PAD_CFG_BASE + `PAD_CFG_SIZE) begin
      idx = int'((addr - `PAD_CFG_BASE) >> 2);
      if (idx < `PAD_COUNT) begin
        pad_model[idx] = wdata[`PAD_SEL_W-1:0];
      end
    end
  endtask

  function automatic apb_data_t pad_expect(input int idx);
    apb_data_t v;
    v = '0;
    if (idx < `PAD_COUNT) begin
      v = apb_data_t'(pad_model[idx]);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // APB access
  //////////////////////////////////////////////////////////////////////

  // Setup, access, then wait for pready, sampled on the falling edge
  task automatic bus_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            input logic pad_byp, input logic jtag_byp,
                            output apb_data_t rdata, output logic err);
    @(posedge clk_soc_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    pad_clk_byp     <= pad_byp;
    jtag_clk_byp    <= jtag_byp;
    @(posedge clk_soc_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_soc_i);
    while (!apb_rsp.pready) begin
      @(negedge clk_soc_i);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // This edge ends the access phase
    @(posedge clk_soc_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic check_idle();
    check_value("pready", 32'(apb_rsp.pready), 32'h0);
    check_value("pslverr", 32'(apb_rsp.pslverr), 32'h0);
  endtask

  // Outputs are checked one cycle after the access phase
  task automatic run_pattern(input pattern_t p);
    apb_data_t rdata;
    logic      err;
    bus_access(p.wr, p.addr, p.wdata, p.pad_byp, p.jtag_byp, rdata, err);
    update_pad_model(p.wr, p.addr, p.wdata);
    if (!p.wr) begin
      check_value("prdata", rdata, p.exp_rdata);
    end
    check_value("pslverr", 32'(err), 32'(p.exp_err));
    @(negedge clk_soc_i);
    check_value("clk_ctrl_o", 32'(clk_ctrl), 32'(p.exp_clk));
    check_value("pad_cfg_o", 32'(pad_cfg), 32'(pad_model));
    check_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int        idx;
    apb_addr_t addr;
    apb_data_t data;
    apb_data_t rdata;
    logic      err;
    apb_req      = '0;
    pad_clk_byp  = 1'b0;
    jtag_clk_byp = 1'b0;
    rst_n        = 1'b0;
    pad_model    = '0;
    seed         = 32'h8262df5d;
    load_patterns();
    // Four cycles per access covers setup, access and the check cycle
    limit = (pats.size() + 2 * RAND_WRITES) * 4 + 50;
    repeat (3) @(posedge clk_soc_i);
    rst_n <= 1'b1;
    @(negedge clk_soc_i);
    // All clocks on, no bypass, every pad on function 0
    check_value("clk_ctrl_o", 32'(clk_ctrl), 32'h2a);
    check_value("pad_cfg_o", 32'(pad_cfg), 32'h0);
    check_idle();
    foreach (pats[i]) begin
      run_pattern(pats[i]);
    end
    // Random pad writes, indices 8 to 15 must change nothing
    for (int n = 0; n < RAND_WRITES; n++) begin
      seed = lcg_next(seed);
      idx  = int'(seed[27:24]);
      seed = lcg_next(seed);
      data = seed;
      addr = `PAD_CFG_BASE + apb_addr_t'(idx * 4);
      bus_access(1'b1, addr, data, 1'b0, 1'b0, rdata, err);
      update_pad_model(1'b1, addr, data);
      check_value("pslverr", 32'(err), 32'h0);
      @(negedge clk_soc_i);
      check_value("pad_cfg_o", 32'(pad_cfg), 32'(pad_model));
      bus_access(1'b0, addr, '0, 1'b0, 1'b0, rdata, err);
      check_value("prdata", rdata, pad_expect(idx));
      check_value("pslverr", 32'(err), 32'h0);
    end
    @(negedge clk_soc_i);
    check_value("clk_ctrl_o", 32'(clk_ctrl), 32'h2a);
    $display("TEST OK");
    $finish;
  end

endmodule
